/* project.f */
common/cpu_pkg.sv
source/cpu_alu.sv
source/cpu_regfile.sv
source/cpu_branch_cond.sv
control/cpu_control.sv
source/cpu_top.sv
test/tb_mem_model.sv
test/tb_cpu_top.sv

/* test/tb_cpu_top.sv */
`timescale 1ns/1ns

module tb_cpu_top import cpu_pkg::*; ();

    localparam reg_addr_t BASE = 5'd29;  // store base register
    localparam reg_addr_t TMP = 5'd28;

    logic       clk;
    logic       rst_n;
    mem_bus_t   mem;
    half_t      rdata;
    cpu_flags_t ccr;
    logic       fault;

    integer     seed = 43;
    half_t      prog [$];
    word_t      pre_addr [$];
    half_t      pre_data [$];
    word_t      exp_addr [$];
    half_t      exp_data [$];
    logic [3:0] exp_ccr [$];
    word_t      mregs [32];
    logic [3:0] mccr;  // c n v z
    word_t      cmp_a, cmp_b;
    int         st_off;

    cpu_top #(.RESET_PC(32'h0), .MEM_WAIT(3)) cpu_top_inst (
        .clk(clk),
        .rst_n(rst_n),
        .mem(mem),
        .rdata(rdata),
        .ccr(ccr),
        .fault(fault)
    );

    tb_mem_model mem_inst (.clk(clk), .mem(mem), .rdata(rdata));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(string name, word_t got, word_t exp);
        assert (got == exp) else begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic fail(string what);
        $display("Error at %0t: %s", $time, what);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    function automatic word_t ref_alu(logic [3:0] f, word_t a, word_t b);
        case (f)
            4'h0: return a & b;
            4'h1: return a | b;
            4'h2: return a + b;
            4'h3: return a - b;
            4'h4: return a ^ b;
            4'h5: return a << b[4:0];
            4'h6: return a >> b[4:0];
            default: return a;
        endcase
    endfunction

    function automatic logic [3:0] ref_cmp_flags(word_t a, word_t b);
        longint diff;
        word_t  r;
        diff = longint'($signed(a)) - longint'($signed(b));
        r = a - b;
        return {a < b, r[31], (diff > 64'sd2147483647) || (diff < -64'sd2147483648), a == b};
    endfunction

    // decided from the compared operands, not from the flags
    function automatic logic ref_taken(logic [7:0] opc, word_t a, word_t b);
        case (opc)
            8'h20: return 1'b1;
            8'h21: return a == b;
            8'h22: return a != b;
            8'h23: return a > b;
            8'h24: return $signed(a) > $signed(b);
            8'h25: return $signed(a) >= $signed(b);
            8'h26: return $signed(a) <= $signed(b);
            8'h27: return $signed(a) < $signed(b);
            8'h28: return a >= b;
            8'h29: return a < b;
            8'h2a: return a <= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic half_t enc(logic [2:0] mode, logic [7:0] opc, reg_addr_t ra);
        return {mode, opc, ra};
    endfunction

    task automatic emit2(half_t w1, half_t w2);
        prog.push_back(w1);
        prog.push_back(w2);
    endtask

    task automatic do_lds(reg_addr_t ra, half_t imm);
        emit2(enc(3'd1, 8'h21, ra), imm);
        mregs[ra] = {{16{imm[15]}}, imm};
    endtask

    task automatic do_ldu(reg_addr_t ra, half_t imm);
        emit2(enc(3'd1, 8'h22, ra), imm);
        mregs[ra] = {16'h0000, imm};
    endtask

    task automatic do_alu_reg(logic [3:0] f, reg_addr_t ra, reg_addr_t rb, reg_addr_t rc);
        emit2(enc(3'd3, {4'h0, f}, ra), {3'b000, rb, 3'b000, rc});
        mregs[ra] = ref_alu(f, mregs[rb], mregs[rc]);
    endtask

    task automatic do_alu_imm(logic [3:0] f, reg_addr_t ra, half_t imm);
        emit2(enc(3'd1, {4'h1, f}, ra), imm);
        mregs[ra] = ref_alu(f, mregs[ra], {{16{imm[15]}}, imm});
    endtask

    task automatic do_unary(logic [7:0] opc, reg_addr_t ra, reg_addr_t rb);
        emit2(enc(3'd3, opc, ra), {3'b000, rb, 8'h00});
        case (opc)
            8'h10: mregs[ra] = mregs[rb];
            8'h12: mregs[ra] = 32'd0 - mregs[rb];
            8'h17: mregs[ra] = ~mregs[rb];
            default: begin  // cmp, ra minus rb
                mccr = ref_cmp_flags(mregs[ra], mregs[rb]);
                cmp_a = mregs[ra];
                cmp_b = mregs[rb];
            end
        endcase
    endtask

    task automatic do_incdec(logic [7:0] opc, reg_addr_t ra);
        prog.push_back(enc(3'd3, opc, ra));
        mregs[ra] = (opc == 8'h13) ? mregs[ra] + 32'd1 : mregs[ra] - 32'd1;
    endtask

    task automatic do_st(reg_addr_t ra, reg_addr_t rb, logic [10:0] off, logic expect_it);
        emit2(enc(3'd2, 8'h30, ra), {rb, off});
        if (expect_it) begin
            exp_addr.push_back(mregs[rb] + {{21{off[10]}}, off});
            exp_data.push_back(mregs[ra][15:0]);
            exp_ccr.push_back(mccr);
        end
    endtask

    task automatic do_ld(reg_addr_t ra, reg_addr_t rb, logic [10:0] off, half_t value);
        pre_addr.push_back(mregs[rb] + {{21{off[10]}}, off});
        pre_data.push_back(value);
        emit2(enc(3'd2, 8'h31, ra), {rb, off});
        mregs[ra] = {16'h0000, value};
    endtask

    task automatic store32(reg_addr_t ra);
        do_st(ra, BASE, 11'(st_off), 1'b1);
        do_unary(8'h10, TMP, ra);
        do_alu_imm(4'h6, TMP, 16'd16);
        do_st(TMP, BASE, 11'(st_off + 2), 1'b1);
        st_off += 4;
    endtask

    task automatic load32(reg_addr_t ra, word_t v);
        do_lds(ra, v[31:16]);
        do_alu_imm(4'h5, ra, 16'd16);
        do_ldu(TMP, v[15:0]);
        do_alu_reg(4'h1, ra, ra, TMP);
    endtask

    task automatic start_program();
        prog.delete();
        pre_addr.delete();
        pre_data.delete();
        exp_addr.delete();
        exp_data.delete();
        exp_ccr.delete();
        foreach (mregs[i]) mregs[i] = '0;
        mccr = '0;
        st_off = 0;
        do_lds(BASE, 16'h1000);
    endtask

    task automatic run_program();
        int cycles;
        emit2(enc(3'd5, 8'h20, 5'd0), 16'hfffc);  // bra to itself
        @(negedge clk);
        rst_n = 1'b0;
        mem_inst.fill();
        foreach (prog[i]) mem_inst.words[i] = prog[i];
        foreach (pre_addr[i]) mem_inst.words[pre_addr[i] >> 1] = pre_data[i];
        mem_inst.clear_log();
        repeat (8) begin
            @(negedge clk);
            check_value("mem.write", mem.write, 0);
            check_value("fault", fault, 0);
            check_value("ccr", ccr, 0);
            check_value("mem.addr", mem.addr, 0);
        end
        check_value("write count in reset", mem_inst.log_addr.size(), 0);
        rst_n = 1'b1;
        for (int idx = 0; idx < exp_addr.size(); idx++) begin
            cycles = 0;
            while (mem_inst.log_addr.size() <= idx) begin
                @(negedge clk);
                cycles++;
                if (cycles > 2000) fail("timeout waiting for a memory write");
            end
            check_value("mem.addr", mem_inst.log_addr[idx], exp_addr[idx]);
            check_value("mem.wdata", mem_inst.log_data[idx], exp_data[idx]);
            check_value("ccr", ccr, exp_ccr[idx]);
        end
    endtask

    task automatic check_quiet(int n);
        repeat (n) @(negedge clk);
        check_value("write count", mem_inst.log_addr.size(), exp_addr.size());
    endtask

    task automatic reset_test();
        start_program();
        do_ldu(5'd1, 16'h5aa5);
        do_st(5'd1, BASE, 11'd0, 1'b1);
        run_program();
        check_quiet(100);
    endtask

    task automatic arith_test();
        half_t imm;
        start_program();
        for (int f = 0; f < 7; f++) begin
            load32(5'd1, $random(seed));
            load32(5'd2, $random(seed));
            imm = $random(seed);
            do_alu_reg(4'(f), 5'd3, 5'd1, 5'd2);
            store32(5'd3);
            do_alu_imm(4'(f), 5'd1, imm);
            store32(5'd1);
        end
        do_lds(5'd4, $random(seed));
        store32(5'd4);
        do_incdec(8'h13, 5'd4);
        store32(5'd4);
        do_incdec(8'h14, 5'd4);
        do_incdec(8'h14, 5'd4);
        store32(5'd4);
        do_unary(8'h10, 5'd5, 5'd4);
        store32(5'd5);
        do_unary(8'h12, 5'd6, 5'd4);
        store32(5'd6);
        do_unary(8'h17, 5'd7, 5'd4);
        store32(5'd7);
        run_program();
        check_quiet(200);
    endtask

    task automatic mem_test();
        logic [10:0] offs [4] = '{11'h010, 11'h7e0, 11'h3fe, 11'h400};
        start_program();
        do_lds(5'd10, 16'h2800);
        foreach (offs[k]) begin
            do_ld(5'd11, 5'd10, offs[k], $random(seed));
            store32(5'd11);
        end
        do_ldu(5'd12, $random(seed));
        store32(5'd12);
        do_ldu(5'd12, 16'h8001);  // no sign extension
        store32(5'd12);
        run_program();
        check_quiet(200);
    endtask

    task automatic branch_test();
        logic [7:0] bops [12] = '{8'h20, 8'h21, 8'h22, 8'h23, 8'h24, 8'h25,
                                  8'h26, 8'h27, 8'h28, 8'h29, 8'h2a, 8'h2c};
        word_t ea [6] = '{32'h5, 32'h7fffffff, 32'h80000000, 32'h0, 32'hffffffff, 32'h1};
        word_t eb [6] = '{32'h5, 32'h80000000, 32'h7fffffff, 32'h1, 32'h1, 32'hffffffff};
        start_program();
        for (int p = 0; p < 10; p++) begin
            load32(5'd1, (p < 6) ? ea[p] : word_t'($random(seed)));
            load32(5'd2, (p < 6) ? eb[p] : word_t'($random(seed)));
            do_unary(8'h11, 5'd1, 5'd2);
            foreach (bops[k]) begin
                do_ldu(5'd25, 16'(p * 16 + k));
                emit2(enc(3'd5, bops[k], 5'd0), 16'h0004);  // skips the marker
                do_st(5'd25, BASE, 11'(st_off), !ref_taken(bops[k], cmp_a, cmp_b));
                st_off += 2;
            end
        end
        run_program();
        check_quiet(200);
    endtask

    task automatic flow_test();
        word_t target;
        start_program();
        do_ldu(5'd1, 16'h00aa);
        prog.push_back(enc(3'd0, 8'h00, 5'd0));
        prog.push_back(enc(3'd0, 8'h00, 5'd0));
        do_st(5'd1, BASE, 11'd0, 1'b1);
        target = 2 * prog.size() + 16;  // past lds, jmp and two stores
        do_lds(5'd20, 16'(target + 8));
        emit2(enc(3'd2, 8'h50, 5'd0), {5'd20, 11'h7f8});
        do_st(5'd1, BASE, 11'd2, 1'b0);
        do_st(5'd1, BASE, 11'd4, 1'b0);
        do_st(5'd1, BASE, 11'd6, 1'b1);
        target = 2 * prog.size() + 12;
        do_lds(5'd21, 16'(target));
        emit2(enc(3'd2, 8'h50, 5'd0), {5'd21, 11'h000});
        do_st(5'd1, BASE, 11'd8, 1'b0);
        prog.push_back(enc(3'd0, 8'h00, 5'd0));
        do_st(5'd1, BASE, 11'd10, 1'b1);
        run_program();
        check_quiet(300);
    endtask

    task automatic fault_test(half_t w1, half_t w2);
        word_t addr_hold;
        int    cycles;
        start_program();
        do_ldu(5'd1, 16'h0bad);
        do_st(5'd1, BASE, 11'd0, 1'b1);
        emit2(w1, w2);
        run_program();
        cycles = 0;
        while (!fault) begin
            @(negedge clk);
            cycles++;
            if (cycles > 100) fail("fault not raised after an undefined instruction");
        end
        addr_hold = mem.addr;
        repeat (50) begin
            @(negedge clk);
            check_value("fault", fault, 1);
            check_value("mem.write", mem.write, 0);
            check_value("mem.addr", mem.addr, addr_hold);
        end
        check_quiet(0);
    endtask

    initial begin
        rst_n = 1'b0;
        reset_test();
        arith_test();
        mem_test();
        branch_test();
        flow_test();
        fault_test(16'h8000, 16'h0000);  // mode 4 is undefined
        fault_test(enc(3'd3, 8'h15, 5'd1), 16'h0000);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* test/tb_mem_model.sv */
`timescale 1ns/1ns

module tb_mem_model import cpu_pkg::*; #(
    parameter int WORDS = 8192
) (
    input  logic     clk,
    input  mem_bus_t mem,
    output half_t    rdata
);

    half_t words [WORDS];
    word_t log_addr [$];
    half_t log_data [$];
    word_t word_idx;

    assign word_idx = mem.addr >> 1;

    // outside the array a read returns a folded address
    assign rdata = (word_idx < WORDS) ? words[word_idx] : (mem.addr[15:0] ^ mem.addr[31:16]);

    always @(posedge clk) begin
        if (mem.write) begin
            log_addr.push_back(mem.addr);
            log_data.push_back(mem.wdata);
            if (word_idx < WORDS) begin
                words[word_idx] <= mem.wdata;
            end
        end
    end

    task automatic fill();
        for (int i = 0; i < WORDS; i++) begin
            words[i] = 16'(i * 32'h2f1b) ^ 16'h5a3c;  // odd multiplier mixes every bit
        end
    endtask

    task automatic clear_log();
        log_addr.delete();
        log_data.delete();
    endtask

endmodule

/* source/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top import cpu_pkg::*; #(
    parameter word_t       RESET_PC = 32'hffc0_0000,
    parameter int unsigned MEM_WAIT = 3
) (
    input  logic       clk,
    input  logic       rst_n,
    output mem_bus_t   mem,
    input  half_t      rdata,
    output cpu_flags_t ccr,
    output logic       fault
);

    reg_addr_t  rd_addr1, rd_addr2;
    word_t      rd_data1, rd_data2;
    reg_wr_t    reg_wr;
    word_t      alu_in1, alu_in2, alu_result;
    alu_op_e    alu_op;
    cpu_flags_t alu_flags;
    opcode_e    op;
    logic       taken;

    cpu_control #(
        .RESET_PC(RESET_PC),
        .MEM_WAIT(MEM_WAIT)
    ) control_inst (
        .clk(clk),
        .rst_n(rst_n),
        .rdata(rdata),
        .rd_data1(rd_data1),
        .rd_data2(rd_data2),
        .alu_result(alu_result),
        .alu_flags(alu_flags),
        .taken(taken),
        .mem(mem),
        .rd_addr1(rd_addr1),
        .rd_addr2(rd_addr2),
        .reg_wr(reg_wr),
        .alu_in1(alu_in1),
        .alu_in2(alu_in2),
        .alu_op(alu_op),
        .op(op),
        .ccr(ccr),
        .fault(fault)
    );

    cpu_alu alu_inst (
        .in1(alu_in1),
        .in2(alu_in2),
        .op(alu_op),
        .result(alu_result),
        .flags(alu_flags)
    );

    cpu_regfile regfile_inst (
        .clk(clk),
        .rst_n(rst_n),
        .rd_addr1(rd_addr1),
        .rd_addr2(rd_addr2),
        .wr(reg_wr),
        .rd_data1(rd_data1),
        .rd_data2(rd_data2)
    );

    cpu_branch_cond branch_inst (
        .op(op),
        .ccr(ccr),
        .taken(taken)
    );

endmodule

/* control/cpu_control.sv */
`timescale 1ns/1ns

module cpu_control import cpu_pkg::*; #(
    parameter word_t       RESET_PC = 32'hffc0_0000,
    parameter int unsigned MEM_WAIT = 3
) (
    input  logic       clk,
    input  logic       rst_n,
    input  half_t      rdata,
    input  word_t      rd_data1,
    input  word_t      rd_data2,
    input  word_t      alu_result,
    input  cpu_flags_t alu_flags,
    input  logic       taken,
    output mem_bus_t   mem,
    output reg_addr_t  rd_addr1,
    output reg_addr_t  rd_addr2,
    output reg_wr_t    reg_wr,
    output word_t      alu_in1,
    output word_t      alu_in2,
    output alu_op_e    alu_op,
    output opcode_e    op,
    output cpu_flags_t ccr,
    output logic       fault
);

    cpu_state_e state, state_next;
    word_t      pc, pc_next;
    half_t      ir, ir_next;
    word_t      mar, mar_next;
    word_t      mdr, mdr_next;
    cpu_flags_t ccr_next;
    logic [7:0] wait_cnt, wait_cnt_next;

    addr_mode_e mode;
    reg_addr_t  ra;
    logic       word_done;
    logic       data_phase;

    assign mode = addr_mode_e'(ir[15:13]);
    assign op = opcode_e'(ir[12:5]);
    assign ra = ir[4:0];
    assign word_done = (wait_cnt == 8'(MEM_WAIT));  // last cycle of a fetch

    // load and store put mar on the bus, everything else pc
    assign data_phase = (state == s_store) || (state == s_load) || (state == s_load2);
    assign mem = '{addr: data_phase ? mar : pc, wdata: mdr[15:0], write: state == s_store};
    assign fault = (state == s_fault);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= s_fetch1;
            pc <= RESET_PC;
            ccr <= '0;
            wait_cnt <= '0;
        end else begin
            state <= state_next;
            pc <= pc_next;
            ccr <= ccr_next;
            wait_cnt <= wait_cnt_next;
        end
    end

    always_ff @(posedge clk) begin
        ir <= ir_next;
        mar <= mar_next;
        mdr <= mdr_next;
    end

    always_comb begin
        state_next = state;
        pc_next = pc;
        ir_next = ir;
        mar_next = mar;
        mdr_next = mdr;
        ccr_next = ccr;
        wait_cnt_next = wait_cnt;
        rd_addr1 = ra;
        rd_addr2 = mdr[12:8];
        alu_in1 = rd_data1;
        alu_in2 = rd_data2;
        alu_op = alu_add;
        reg_wr = '{addr: ra, data: alu_result, en: 1'b0};

        case (state)
            s_fetch1, s_fetch2: begin
                wait_cnt_next = wait_cnt + 8'd1;
                if (word_done) begin
                    wait_cnt_next = '0;
                    pc_next = pc + INSN_BYTES;
                    if (state == s_fetch1) begin
                        ir_next = rdata;
                        state_next = s_eval1;
                    end else begin
                        mdr_next = {16'h0000, rdata};
                        mar_next = {{21{rdata[10]}}, rdata[10:0]};  // regind offset
                        if (mode == am_imm || mode == am_pcind) begin
                            mdr_next = {{16{rdata[15]}}, rdata};
                        end
                        state_next = s_eval2;
                    end
                end
            end

            s_eval1: begin
                case (mode)
                    am_inh: state_next = (op == op_nop) ? s_fetch1 : s_fault;
                    am_reg: begin
                        if (op == op_inc || op == op_dec) begin
                            alu_in2 = 32'd1;
                            alu_op = (op == op_inc) ? alu_add : alu_sub;
                            reg_wr.en = 1'b1;
                            state_next = s_fetch1;
                        end else begin
                            state_next = s_fetch2;
                        end
                    end
                    am_imm, am_regind, am_pcind: state_next = s_fetch2;
                    default: state_next = s_fault;
                endcase
            end

            s_eval2: begin
                state_next = s_fetch1;
                case (mode)
                    am_reg: begin
                        rd_addr1 = mdr[12:8];  // rB
                        rd_addr2 = mdr[4:0];   // rC
                        if (op[7:4] == 4'h0) begin
                            alu_op = alu_op_e'(op[3:0]);
                            reg_wr.en = 1'b1;
                        end else begin
                            case (op)
                                op_mov: begin
                                    reg_wr.data = rd_data1;
                                    reg_wr.en = 1'b1;
                                end
                                op_cmp: begin
                                    rd_addr1 = ra;
                                    rd_addr2 = mdr[12:8];
                                    alu_op = alu_sub;
                                    ccr_next = alu_flags;  // only cmp touches ccr
                                end
                                op_neg: begin
                                    alu_in1 = '0;
                                    alu_in2 = rd_data1;
                                    alu_op = alu_sub;
                                    reg_wr.en = 1'b1;
                                end
                                op_com: begin
                                    reg_wr.data = ~rd_data1;
                                    reg_wr.en = 1'b1;
                                end
                                default: state_next = s_fault;
                            endcase
                        end
                    end
                    am_imm: begin
                        alu_in2 = mdr;
                        if (op[7:4] == 4'h1) begin
                            alu_op = alu_op_e'(op[3:0]);
                            reg_wr.en = 1'b1;
                        end else if (op == op_lds) begin
                            reg_wr.data = mdr;
                            reg_wr.en = 1'b1;
                        end else if (op == op_ldu) begin
                            reg_wr.data = {16'h0000, mdr[15:0]};
                            reg_wr.en = 1'b1;
                        end else begin
                            state_next = s_fault;
                        end
                    end
                    am_regind: begin
                        rd_addr1 = mdr[15:11];  // base rB
                        rd_addr2 = ra;
                        alu_in2 = mar;
                        case (op)
                            op_st: begin
                                mar_next = alu_result;
                                mdr_next = rd_data2;
                                state_next = s_store;
                            end
                            op_ld: begin
                                mar_next = alu_result;
                                state_next = s_load;
                            end
                            op_jmp: pc_next = alu_result;
                            default: state_next = s_fault;
                        endcase
                    end
                    am_pcind: begin
                        alu_in1 = pc;  // already points past the branch
                        alu_in2 = mdr;
                        if ((op >= op_bra && op <= op_bleu) || op == op_brn) begin
                            if (taken) begin
                                pc_next = alu_result;
                            end
                        end else begin
                            state_next = s_fault;
                        end
                    end
                    default: state_next = s_fault;
                endcase
            end

            s_store: state_next = s_fetch1;
            s_load:  state_next = s_load2;

            s_load2: begin
                reg_wr.data = {16'h0000, rdata};
                reg_wr.en = 1'b1;
                state_next = s_fetch1;
            end

            s_fault: state_next = s_fault;  // held until reset
            default: state_next = s_fault;
        endcase
    end

endmodule

/* source/cpu_branch_cond.sv */
`timescale 1ns/1ns

module cpu_branch_cond import cpu_pkg::*; (
    input  opcode_e    op,
    input  cpu_flags_t ccr,
    output logic       taken
);

    logic lt_signed;

    assign lt_signed = ccr.negative ^ ccr.overflow;

    always_comb begin
        case (op)
            op_bra:  taken = 1'b1;
            op_beq:  taken = ccr.zero;
            op_bne:  taken = !ccr.zero;
            op_bgtu: taken = !(ccr.carry || ccr.zero);
            op_bgt:  taken = !(ccr.zero || lt_signed);
            op_bge:  taken = !lt_signed;
            op_ble:  taken = ccr.zero || lt_signed;
            op_blt:  taken = lt_signed;
            op_bgeu: taken = !ccr.carry;
            op_bltu: taken = ccr.carry;
            op_bleu: taken = ccr.carry || ccr.zero;
            default: taken = 1'b0;  // brn and the rest
        endcase
    end

endmodule

/* source/cpu_regfile.sv */
`timescale 1ns/1ns

module cpu_regfile import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rd_addr1,
    input  reg_addr_t rd_addr2,
    input  reg_wr_t   wr,
    output word_t     rd_data1,
    output word_t     rd_data2
);

    word_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en) begin
            regs[wr.addr] <= wr.data;  // full word only
        end
    end

    // async reads, a write shows up the next cycle
    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];

endmodule

/* source/cpu_alu.sv */
`timescale 1ns/1ns

module cpu_alu import cpu_pkg::*; (
    input  word_t      in1,
    input  word_t      in2,
    input  alu_op_e    op,
    output word_t      result,
    output cpu_flags_t flags
);

    logic [32:0] sum;  // extra bit holds carry or borrow

    always_comb begin
        sum = {1'b0, in1} + {1'b0, in2};
        result = in1;
        flags.carry = 1'b0;
        flags.overflow = 1'b0;
        case (op)
            alu_and: result = in1 & in2;
            alu_or:  result = in1 | in2;
            alu_xor: result = in1 ^ in2;
            alu_shl: result = in1 << in2[4:0];
            alu_shr: result = in1 >> in2[4:0];
            alu_add: begin
                result = sum[31:0];
                flags.carry = sum[32];
                flags.overflow = (in1[31] == in2[31]) && (sum[31] != in1[31]);
            end
            alu_sub: begin
                sum = {1'b0, in1} - {1'b0, in2};
                result = sum[31:0];
                flags.carry = sum[32];  // borrow, in1 < in2 unsigned
                flags.overflow = (in1[31] != in2[31]) && (sum[31] != in1[31]);
            end
            default: result = in1;
        endcase
        flags.negative = result[31];
        flags.zero = (result == '0);
    end

endmodule

/* common/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [15:0] half_t;
    typedef logic [4:0]  reg_addr_t;

    localparam word_t INSN_BYTES = 32'd2;  // pc step per fetched word

    typedef enum logic [7:0] {
        s_fetch1 = 8'h00,
        s_eval1  = 8'h01,
        s_fetch2 = 8'h02,
        s_eval2  = 8'h03,
        s_store  = 8'h04,
        s_load   = 8'h05,
        s_load2  = 8'h06,
        s_fault  = 8'h07
    } cpu_state_e;

    typedef enum logic [2:0] {
        am_inh    = 3'h0,
        am_imm    = 3'h1,
        am_regind = 3'h2,
        am_reg    = 3'h3,
        am_pcind  = 3'h5
    } addr_mode_e;

    // alu groups 0x0_ (reg) and 0x1_ (imm) are decoded by the high nibble
    typedef enum logic [7:0] {
        op_nop  = 8'h00,
        op_mov  = 8'h10,
        op_cmp  = 8'h11,
        op_neg  = 8'h12,
        op_inc  = 8'h13,
        op_dec  = 8'h14,
        op_com  = 8'h17,
        op_bra  = 8'h20,
        op_beq  = 8'h21,
        op_bne  = 8'h22,
        op_bgtu = 8'h23,
        op_bgt  = 8'h24,
        op_bge  = 8'h25,
        op_ble  = 8'h26,
        op_blt  = 8'h27,
        op_bgeu = 8'h28,
        op_bltu = 8'h29,
        op_bleu = 8'h2a,
        op_brn  = 8'h2c,
        op_st   = 8'h30,
        op_ld   = 8'h31,
        op_jmp  = 8'h50
    } opcode_e;

    // imm-mode loads reuse the codes of beq and bne
    localparam opcode_e op_lds = op_beq;
    localparam opcode_e op_ldu = op_bne;

    typedef enum logic [3:0] {
        alu_and = 4'h0,
        alu_or  = 4'h1,
        alu_add = 4'h2,
        alu_sub = 4'h3,
        alu_xor = 4'h4,
        alu_shl = 4'h5,
        alu_shr = 4'h6
    } alu_op_e;

    typedef struct packed {
        logic carry;
        logic negative;
        logic overflow;
        logic zero;
    } cpu_flags_t;

    typedef struct packed {
        word_t addr;
        half_t wdata;
        logic  write;
    } mem_bus_t;

    typedef struct packed {
        reg_addr_t addr;
        word_t     data;
        logic      en;
    } reg_wr_t;

endpackage
